// File: flist.f
hdl/uart_pkg.sv
hdl/sync_fifo.sv
hdl/uart_tx_shifter.sv
hdl/uart_rx_sampler.sv
hdl/uart_reg_ctrl.sv
hdl/uart_periph.sv
tb/uart_periph_tb.sv

// File: tb/uart_periph_tb.sv
`timescale 1ns/1ps

module uart_periph_tb;

  import uart_pkg::*;

  // frame count over all tests sizes the watchdog
  localparam int n_loop_bytes  = 12;
  localparam int n_ovr_bytes   = 10;
  localparam int n_clr_bytes   = 3;
  localparam int n_frames      = n_loop_bytes + n_ovr_bytes + 1 + n_clr_bytes;
  localparam int frame_clks    = 10 * clks_per_bit;
  localparam longint wdog_ns   = longint'(n_frames + 20) * frame_clks * 8;
  localparam int poll_limit    = 4 * frame_clks;

  logic                  clk;
  logic                  rst_n;
  bus_req_t              bus;
  logic                  serial_in;
  logic [data_width-1:0] bus_rdata;
  logic                  bus_rvalid;
  logic                  serial_out;

  // serial input is either looped back or injected
  logic                  loop_en;
  logic                  inj_bit;

  logic [31:0]           lfsr;
  logic [7:0]            exp_q[$];
  int                    rx_count;
  logic                  ovr_model;
  logic                  ferr_model;
  int                    err_count;
  int                    check_count;

  assign serial_in = loop_en ? serial_out : inj_bit;

  uart_periph i_uart_periph (
    .clk        (clk),
    .rst_n      (rst_n),
    .bus        (bus),
    .serial_in  (serial_in),
    .bus_rdata  (bus_rdata),
    .bus_rvalid (bus_rvalid),
    .serial_out (serial_out)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  initial begin
    #(wdog_ns);
    $display("watchdog expired at %0t, the tests did not finish", $time);
    $display("TEST FAIL");
    $finish;
  end

  // galois form with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // expected status byte from the model state
  function automatic logic [7:0] expect_status(input int rx_n, input int tx_n,
                                               input logic ovr, input logic ferr);
    uart_status_t s;
    s           = '0;
    s.frame_err = ferr;
    s.overrun   = ovr;
    s.rx_half   = rx_n >= 4;
    s.rx_empty  = rx_n == 0;
    s.tx_half   = tx_n >= 4;
    s.tx_full   = tx_n >= 8;
    return s;
  endfunction

  task automatic check_equal(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("FAIL %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic next_rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b[i] = lfsr[0];
    end
  endtask

  task automatic bus_write(input logic [1:0] addr, input logic [7:0] data);
    bus.wr    = 1'b1;
    bus.rd    = 1'b0;
    bus.addr  = addr;
    bus.wdata = data;
    step();
    bus.wr    = 1'b0;
  endtask

  task automatic bus_read(input logic [1:0] addr, output logic [7:0] data);
    bus.rd   = 1'b1;
    bus.wr   = 1'b0;
    bus.addr = addr;
    step();
    bus.rd   = 1'b0;
    check_equal("bus_rvalid one cycle after rd", bus_rvalid, 1'b1);
    data = bus_rdata;
  endtask

  // reads status until the masked bits match or poll_limit reads have passed
  task automatic poll_status(input logic [7:0] mask, input logic [7:0] want,
                             input string what, output logic ok);
    logic [7:0] st;
    int         polls;
    polls = 0;
    ok    = 1'b0;
    while (!ok && polls < poll_limit) begin
      bus_read(addr_status, st);
      ok = (st & mask) == want;
      polls++;
    end
    if (!ok) begin
      err_count++;
      $display("gave up at %0t waiting for %s", $time, what);
    end
  endtask

  // waits for the start bit and then the rest of the fixed-length frame
  task automatic wait_frame_done();
    int waited;
    waited = 0;
    while (serial_out && waited < 4 * clks_per_bit) begin
      step();
      waited++;
    end
    if (serial_out) begin
      err_count++;
      $display("no start bit seen on serial_out at %0t", $time);
    end
    repeat (frame_clks + clks_per_bit) step();
  endtask

  task automatic inject_frame(input logic [7:0] data, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      inj_bit = frame[i];
      repeat (clks_per_bit) step();
    end
    inj_bit = 1'b1;
  endtask

  // sends one byte over the loop and models it against the receive FIFO depth
  task automatic send_and_model(input logic [7:0] b);
    bus_write(addr_data, b);
    if (rx_count < 8) begin
      exp_q.push_back(b);
      rx_count++;
    end else begin
      ovr_model = 1'b1;
    end
  endtask

  initial begin
    logic [7:0] rd;
    logic [7:0] b;
    logic       ok;
    uart_ctrl_t ctrl;

    bus         = '0;
    rst_n       = 1'b1;
    loop_en     = 1'b1;
    inj_bit     = 1'b1;
    lfsr        = 32'h1a53_2924;
    rx_count    = 0;
    ovr_model   = 1'b0;
    ferr_model  = 1'b0;
    err_count   = 0;
    check_count = 0;

    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b0;

    // idle state after reset
    check_equal("bus_rvalid after reset", bus_rvalid, 1'b0);
    for (int i = 0; i < 2 * clks_per_bit; i++) begin
      check_equal("serial_out idle after reset", serial_out, 1'b1);
      step();
    end
    bus_read(addr_status, rd);
    check_equal("status after reset", rd, expect_status(0, 0, 1'b0, 1'b0));

    // loopback writes only while tx_full is low (mask bit 0)
    for (int i = 0; i < n_loop_bytes; i++) begin
      poll_status(8'h01, 8'h00, "transmit FIFO space", ok);
      next_rand_byte(b);
      bus_write(addr_data, b);
      exp_q.push_back(b);
    end
    while (exp_q.size() > 0) begin
      // rx_empty is bit 2
      poll_status(8'h04, 8'h00, "loopback receive data", ok);
      if (!ok) begin
        break;
      end
      bus_read(addr_data, rd);
      check_equal("loopback byte", rd, exp_q.pop_front());
    end
    exp_q.delete();

    // overrun with the receive FIFO left unread
    rx_count = 0;
    for (int i = 0; i < n_ovr_bytes; i++) begin
      next_rand_byte(b);
      send_and_model(b);
      wait_frame_done();
    end
    bus_read(addr_status, rd);
    check_equal("status after overrun", rd, expect_status(rx_count, 0, ovr_model, ferr_model));
    while (exp_q.size() > 0) begin
      bus_read(addr_data, rd);
      check_equal("byte kept before overrun", rd, exp_q.pop_front());
      rx_count--;
    end
    bus_read(addr_status, rd);
    check_equal("status after draining", rd, expect_status(rx_count, 0, ovr_model, ferr_model));

    // a byte with a low stop bit is dropped and sets frame_err
    loop_en = 1'b0;
    next_rand_byte(b);
    inject_frame(b, 1'b0);
    ferr_model = 1'b1;
    poll_status(8'h20, 8'h20, "frame_err", ok);
    bus_read(addr_status, rd);
    check_equal("status after bad stop bit", rd, expect_status(rx_count, 0, ovr_model, ferr_model));
    ctrl          = '0;
    ctrl.flag_clr = 1'b1;
    bus_write(addr_ctrl, ctrl);
    ovr_model  = 1'b0;
    ferr_model = 1'b0;
    bus_read(addr_status, rd);
    check_equal("status after flag_clr", rd, expect_status(rx_count, 0, ovr_model, ferr_model));
    loop_en = 1'b1;

    // receive FIFO clear with bytes waiting
    for (int i = 0; i < n_clr_bytes; i++) begin
      next_rand_byte(b);
      send_and_model(b);
      wait_frame_done();
    end
    bus_read(addr_status, rd);
    check_equal("status before rx_clr", rd, expect_status(rx_count, 0, ovr_model, ferr_model));
    ctrl        = '0;
    ctrl.rx_clr = 1'b1;
    bus_write(addr_ctrl, ctrl);
    exp_q.delete();
    rx_count = 0;
    bus_read(addr_status, rd);
    check_equal("status after rx_clr", rd, expect_status(rx_count, 0, ovr_model, ferr_model));

    repeat (4) step();
    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: hdl/uart_periph.sv
`timescale 1ns/1ps

module uart_periph (
  input  logic                            clk,
  input  logic                            rst_n,
  input  uart_pkg::bus_req_t              bus,
  input  logic                            serial_in,
  output logic [uart_pkg::data_width-1:0] bus_rdata,
  output logic                            bus_rvalid,
  output logic                            serial_out
);

  import uart_pkg::*;

  // register side strobes
  logic                  tx_push;
  logic                  tx_clr;
  logic                  rx_pop;
  logic                  rx_clr;

  // transmit path
  logic                  tx_full;
  logic                  tx_half;
  logic                  tx_empty;
  logic                  tx_pop;
  logic [data_width-1:0] tx_data;

  // receive path
  logic                  rx_push;
  logic [data_width-1:0] rx_byte;
  logic                  rx_full;
  logic                  rx_half;
  logic                  rx_empty;
  logic [data_width-1:0] rx_data;
  logic                  frame_err_pulse;

  uart_reg_ctrl i_reg_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .bus             (bus),
    .rx_data         (rx_data),
    .tx_full         (tx_full),
    .tx_half         (tx_half),
    .rx_empty        (rx_empty),
    .rx_half         (rx_half),
    .rx_full         (rx_full),
    .rx_push         (rx_push),
    .frame_err_pulse (frame_err_pulse),
    .bus_rdata       (bus_rdata),
    .bus_rvalid      (bus_rvalid),
    .tx_push         (tx_push),
    .tx_clr          (tx_clr),
    .rx_pop          (rx_pop),
    .rx_clr          (rx_clr)
  );

  sync_fifo #(
    .addr_width (fifo_addr_width),
    .data_width (data_width)
  ) i_tx_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr         (tx_clr),
    .w_inc       (tx_push),
    .w_data      (bus.wdata),
    .w_full      (tx_full),
    .w_half_full (tx_half),
    .r_inc       (tx_pop),
    .r_empty     (tx_empty),
    .r_data      (tx_data)
  );

  sync_fifo #(
    .addr_width (fifo_addr_width),
    .data_width (data_width)
  ) i_rx_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .clr         (rx_clr),
    .w_inc       (rx_push),
    .w_data      (rx_byte),
    .w_full      (rx_full),
    .w_half_full (rx_half),
    .r_inc       (rx_pop),
    .r_empty     (rx_empty),
    .r_data      (rx_data)
  );

  uart_tx_shifter i_tx_shifter (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_empty (tx_empty),
    .fifo_data  (tx_data),
    .fifo_pop   (tx_pop),
    .serial_out (serial_out),
    .busy       ()
  );

  uart_rx_sampler i_rx_sampler (
    .clk             (clk),
    .rst_n           (rst_n),
    .serial_in       (serial_in),
    .rx_push         (rx_push),
    .rx_byte         (rx_byte),
    .frame_err_pulse (frame_err_pulse)
  );

endmodule

// File: hdl/uart_reg_ctrl.sv
`timescale 1ns/1ps

module uart_reg_ctrl (
  input  logic                            clk,
  input  logic                            rst_n,
  input  uart_pkg::bus_req_t              bus,
  input  logic [uart_pkg::data_width-1:0] rx_data,
  input  logic                            tx_full,
  input  logic                            tx_half,
  input  logic                            rx_empty,
  input  logic                            rx_half,
  input  logic                            rx_full,
  input  logic                            rx_push,
  input  logic                            frame_err_pulse,
  output logic [uart_pkg::data_width-1:0] bus_rdata,
  output logic                            bus_rvalid,
  output logic                            tx_push,
  output logic                            tx_clr,
  output logic                            rx_pop,
  output logic                            rx_clr
);

  import uart_pkg::*;

  uart_ctrl_t   ctrl_wr;
  uart_status_t status;
  logic         ctrl_sel;
  logic         flag_clr;
  logic         overrun;
  logic         frame_err;

  // access decode
  assign ctrl_wr  = bus.wdata;
  assign ctrl_sel = bus.wr && (bus.addr == addr_ctrl);
  assign tx_push  = bus.wr && (bus.addr == addr_data);
  assign rx_pop   = bus.rd && (bus.addr == addr_data);
  assign tx_clr   = ctrl_sel && ctrl_wr.tx_clr;
  assign rx_clr   = ctrl_sel && ctrl_wr.rx_clr;
  assign flag_clr = ctrl_sel && ctrl_wr.flag_clr;

  // a new event in the clear cycle still sets the sticky flags
  always_ff @(posedge clk) begin
    if (rst_n) begin
      overrun   <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      if (flag_clr) begin
        overrun   <= 1'b0;
        frame_err <= 1'b0;
      end
      // byte arrived with nowhere to go
      if (rx_push && rx_full) begin
        overrun <= 1'b1;
      end
      if (frame_err_pulse) begin
        frame_err <= 1'b1;
      end
    end
  end

  always_comb begin
    status           = '0;
    status.frame_err = frame_err;
    status.overrun   = overrun;
    status.rx_half   = rx_half;
    status.rx_empty  = rx_empty;
    status.tx_half   = tx_half;
    status.tx_full   = tx_full;
  end

  // read data lands one cycle after rd
  always_ff @(posedge clk) begin
    if (rst_n) begin
      bus_rdata  <= '0;
      bus_rvalid <= 1'b0;
    end else begin
      bus_rvalid <= bus.rd;
      if (bus.rd) begin
        case (bus.addr)
          addr_data:   bus_rdata <= rx_data;
          addr_status: bus_rdata <= status;
          default:     bus_rdata <= '0;
        endcase
      end
    end
  end

  a_rvalid_follows_rd: assert property (
    @(posedge clk) disable iff (rst_n)
    bus.rd |=> bus_rvalid
  );

endmodule

// File: hdl/uart_rx_sampler.sv
`timescale 1ns/1ps

module uart_rx_sampler (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            serial_in,
  output logic                            rx_push,
  output logic [uart_pkg::data_width-1:0] rx_byte,
  output logic                            frame_err_pulse
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } rx_state_e;

  rx_state_e             state;
  logic [1:0]            sync_q;
  logic                  rx_prev;
  logic                  rx_in;
  logic                  fall;
  logic [cnt_width-1:0]  clk_cnt;
  logic [2:0]            bit_cnt;
  logic [data_width-1:0] shreg;
  logic                  mid_bit;
  logic                  bit_end;

  // two-flop synchronizer plus one more for edge detect
  always_ff @(posedge clk) begin
    if (rst_n) begin
      sync_q  <= 2'b11;
      rx_prev <= 1'b1;
    end else begin
      sync_q  <= {sync_q[0], serial_in};
      rx_prev <= sync_q[1];
    end
  end

  assign rx_in   = sync_q[1];
  assign fall    = rx_prev && !rx_in;
  assign mid_bit = clk_cnt == cnt_width'(clks_per_bit / 2 - 1);
  assign bit_end = clk_cnt == cnt_width'(clks_per_bit - 1);

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state           <= st_idle;
      clk_cnt         <= '0;
      bit_cnt         <= '0;
      shreg           <= '0;
      rx_push         <= 1'b0;
      frame_err_pulse <= 1'b0;
    end else begin
      rx_push         <= 1'b0;
      frame_err_pulse <= 1'b0;
      clk_cnt         <= bit_end ? '0 : clk_cnt + 1'b1;
      case (state)
        st_idle: begin
          clk_cnt <= '0;
          if (fall) begin
            state <= st_start;
          end
        end
        st_start: begin
          // after mid-bit the counter restarts so later samples land mid-bit
          if (mid_bit) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
            state   <= rx_in ? st_idle : st_data;
          end
        end
        st_data: begin
          if (bit_end) begin
            shreg   <= {rx_in, shreg[data_width-1:1]};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= st_stop;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= st_idle;
            if (rx_in) begin
              rx_push <= 1'b1;
            end else begin
              // bad stop bit, byte is dropped
              frame_err_pulse <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  assign rx_byte = shreg;

  a_push_xor_err: assert property (
    @(posedge clk) disable iff (rst_n)
    !(rx_push && frame_err_pulse)
  );

endmodule

// File: hdl/uart_tx_shifter.sv
`timescale 1ns/1ps

module uart_tx_shifter (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           fifo_empty,
  input  logic [uart_pkg::data_width-1:0] fifo_data,
  output logic                           fifo_pop,
  output logic                           serial_out,
  output logic                           busy
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } tx_state_e;

  tx_state_e             state;
  logic [cnt_width-1:0]  clk_cnt;
  logic [2:0]            bit_cnt;
  logic [data_width-1:0] shreg;
  logic                  bit_end;

  assign busy     = state != st_idle;
  assign fifo_pop = !busy && !fifo_empty;
  assign bit_end  = clk_cnt == cnt_width'(clks_per_bit - 1);

  // serial_out is registered alongside the state so it never glitches
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state      <= st_idle;
      clk_cnt    <= '0;
      bit_cnt    <= '0;
      shreg      <= '0;
      serial_out <= 1'b1;
    end else begin
      clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
      case (state)
        st_idle: begin
          clk_cnt <= '0;
          if (fifo_pop) begin
            state      <= st_start;
            shreg      <= fifo_data;
            serial_out <= 1'b0;
          end
        end
        st_start: begin
          if (bit_end) begin
            state      <= st_data;
            bit_cnt    <= '0;
            serial_out <= shreg[0];
          end
        end
        st_data: begin
          if (bit_end) begin
            if (bit_cnt == 3'd7) begin
              state      <= st_stop;
              serial_out <= 1'b1;
            end else begin
              // lsb first
              shreg      <= shreg >> 1;
              serial_out <= shreg[1];
              bit_cnt    <= bit_cnt + 1'b1;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  a_idle_high: assert property (
    @(posedge clk) disable iff (rst_n)
    !busy |-> serial_out
  );

endmodule

// File: hdl/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int addr_width = 3,
  parameter int data_width = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clr,

  input  logic                  w_inc,
  input  logic [data_width-1:0] w_data,
  output logic                  w_full,
  output logic                  w_half_full,

  input  logic                  r_inc,
  output logic                  r_empty,
  output logic [data_width-1:0] r_data
);

  logic [data_width-1:0] mem [2**addr_width];

  // pointers carry one extra bit to tell full from empty
  logic [addr_width:0]   w_ptr;
  logic [addr_width:0]   w_ptr_next;
  logic [addr_width:0]   r_ptr;
  logic [addr_width:0]   r_ptr_next;
  logic [addr_width:0]   used;
  logic [addr_width:0]   used_next;
  logic [addr_width-1:0] w_addr;
  logic [addr_width-1:0] r_addr;
  logic                  w_en;
  logic                  r_en;

  assign w_en = w_inc && !w_full;
  assign r_en = r_inc && !r_empty;

  always_comb begin
    w_ptr_next = w_ptr;
    r_ptr_next = r_ptr;
    if (w_en) begin
      w_ptr_next = w_ptr + 1'b1;
    end
    if (r_en) begin
      r_ptr_next = r_ptr + 1'b1;
    end
  end

  assign used      = w_ptr - r_ptr;
  assign used_next = w_ptr_next - r_ptr_next;

  // flags are computed from next-state pointers and registered
  always_ff @(posedge clk) begin
    if (rst_n || clr) begin
      w_ptr       <= '0;
      r_ptr       <= '0;
      w_full      <= 1'b0;
      w_half_full <= 1'b0;
      r_empty     <= 1'b1;
    end else begin
      w_ptr       <= w_ptr_next;
      r_ptr       <= r_ptr_next;
      w_full      <= (w_ptr_next[addr_width] != r_ptr_next[addr_width]) &&
                     (w_ptr_next[addr_width-1:0] == r_ptr_next[addr_width-1:0]);
      w_half_full <= used_next >= (addr_width + 1)'(1 << (addr_width - 1));
      r_empty     <= w_ptr_next == r_ptr_next;
    end
  end

  assign w_addr = w_ptr[addr_width-1:0];
  assign r_addr = r_ptr[addr_width-1:0];

  always_ff @(posedge clk) begin
    if (w_en) begin
      mem[w_addr] <= w_data;
    end
  end

  // head word falls through from the registered read address
  assign r_data = mem[r_addr];

  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst_n)
    used <= (addr_width + 1)'(1 << addr_width)
  );

  a_clr_empties: assert property (
    @(posedge clk) disable iff (rst_n)
    clr |=> r_empty && !w_full && !w_half_full
  );

endmodule

// File: hdl/uart_pkg.sv
package uart_pkg;

  // byte and FIFO geometry
  localparam int data_width      = 8;
  localparam int fifo_addr_width = 3;

  // bit period in clocks, short so frames simulate quickly
  localparam int clks_per_bit = 8;
  localparam int cnt_width    = $clog2(clks_per_bit);

  // register map
  localparam logic [1:0] addr_data   = 2'd0;
  localparam logic [1:0] addr_status = 2'd1;
  localparam logic [1:0] addr_ctrl   = 2'd2;

  // one host access, held for a single cycle
  typedef struct packed {
    logic                  wr;
    logic                  rd;
    logic [1:0]            addr;
    logic [data_width-1:0] wdata;
  } bus_req_t;

  // status register layout, msb first
  typedef struct packed {
    logic [1:0] pad;
    logic       frame_err;
    logic       overrun;
    logic       rx_half;
    logic       rx_empty;
    logic       tx_half;
    logic       tx_full;
  } uart_status_t;

  // control register layout, each bit is a one-cycle strobe
  typedef struct packed {
    logic [4:0] unused;
    logic       flag_clr;
    logic       rx_clr;
    logic       tx_clr;
  } uart_ctrl_t;

endpackage
